//--- rtl/farm_pkg.sv
// Sensor link package with widths, protocol constants and FSM state types
package farm_pkg;

  // ====================================================================
  // Link timing and framing
  // ====================================================================
  localparam int CLKS_PER_BIT  = 16;  // Short bit period keeps sim fast
  localparam int CNT_W         = $clog2(CLKS_PER_BIT);
  localparam int PAYLOAD_BYTES = 6;   // Temp, hum, light, soil, faults, actuator

  typedef logic [7:0]       byte_t;     // One UART byte
  typedef logic [1:0]       level_t;    // Sensor class 0..3
  typedef logic [7:0]       fault_t;    // Fault flag byte
  typedef logic [2:0]       alert_t;    // Alert severity
  typedef logic [2:0]       led_t;      // Status LEDs
  typedef logic [CNT_W-1:0] bit_cnt_t;  // Clocks within one bit
  typedef logic [2:0]       bit_idx_t;  // Data bit within a frame
  typedef logic [2:0]       pay_idx_t;  // Payload byte within a packet

  localparam bit_cnt_t BIT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);
  localparam bit_cnt_t BIT_HALF = bit_cnt_t'((CLKS_PER_BIT - 1) / 2);  // Mid start bit
  localparam pay_idx_t PAY_LAST = pay_idx_t'(PAYLOAD_BYTES - 1);

  // ====================================================================
  // Protocol and decision constants
  // ====================================================================
  localparam byte_t  HEADER_BYTE      = 8'hAA;
  localparam byte_t  ACK_BYTE         = 8'h55;
  localparam level_t OPTIMAL_LEVEL    = 2'd2;
  localparam alert_t ALERT_FAULT      = 3'd7;  // Critical fault
  localparam alert_t ALERT_SUBOPTIMAL = 3'd2;
  localparam alert_t ALERT_NORMAL     = 3'd0;

  // LED bit positions
  localparam int LED_OPTIMAL = 0;
  localparam int LED_FAULT   = 1;
  localparam int LED_CRC     = 2;  // Last packet failed checksum

  // Shared by receiver and transmitter
  typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_t;
  // Packet framing states
  typedef enum logic [1:0] {HUNT, PAYLOAD, CHECK} parse_state_t;

endpackage

//--- rtl/uart_rx.sv
// UART receiver, 8N1 with input synchronizer and start and stop bit checks
`timescale 1ns/1ps

module uart_rx import farm_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx_line,   // Async serial input
  output byte_t rx_data,
  output logic  rx_valid   // One-cycle pulse per good byte
);

  logic        rx_sync1;
  logic        rx_sync2;   // Synchronized line
  uart_state_t state;
  bit_cnt_t    clk_count;
  bit_idx_t    bit_idx;
  byte_t       rx_byte;    // Assembly register

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync1 <= 1'b1;
      rx_sync2 <= 1'b1;
    end else begin
      rx_sync1 <= rx_line;
      rx_sync2 <= rx_sync1;
    end
  end

  // ====================================================================
  // Receive FSM
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      clk_count <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;  // Pulse only
      case (state)
        IDLE: begin
          clk_count <= '0;
          bit_idx   <= '0;
          if (!rx_sync2) state <= START;  // Falling edge seen
        end
        START: begin
          if (clk_count == BIT_HALF) begin
            clk_count <= '0;
            state     <= rx_sync2 ? IDLE : DATA;  // Glitch returns to idle
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        DATA: begin
          if (clk_count == BIT_LAST) begin  // Mid data bit
            clk_count <= '0;
            if (bit_idx == 3'd7) state <= STOP;
            else bit_idx <= bit_idx + 1'b1;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        STOP: begin
          if (clk_count == BIT_LAST) begin
            clk_count <= '0;
            rx_valid  <= rx_sync2;  // Framing error drops the byte
            state     <= IDLE;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data path, LSB first
  always_ff @(posedge clk) begin
    if (state == DATA && clk_count == BIT_LAST) rx_byte[bit_idx] <= rx_sync2;
    if (state == STOP && clk_count == BIT_LAST && rx_sync2) rx_data <= rx_byte;
  end

  // Bytes are at least a frame apart
  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid)
    else $error("rx_valid held for two cycles");

endmodule

//--- rtl/uart_tx.sv
// UART transmitter, sends one 8N1 byte per request
`timescale 1ns/1ps

module uart_tx import farm_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t tx_data,
  input  logic  tx_valid,  // Taken only in IDLE
  output logic  tx_line    // Serial out, idles high
);

  uart_state_t state;
  bit_cnt_t    clk_count;
  bit_idx_t    bit_idx;
  byte_t       tx_byte;    // Latched byte

  // ====================================================================
  // Transmit FSM, tx_line registered one bit ahead of state
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      clk_count <= '0;
      bit_idx   <= '0;
      tx_line   <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          clk_count <= '0;
          bit_idx   <= '0;
          if (tx_valid) begin
            tx_line <= 1'b0;  // Start bit on next cycle
            state   <= START;
          end
        end
        START: begin
          if (clk_count == BIT_LAST) begin
            clk_count <= '0;
            tx_line   <= tx_byte[0];
            state     <= DATA;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        DATA: begin
          if (clk_count == BIT_LAST) begin
            clk_count <= '0;
            if (bit_idx == 3'd7) begin
              tx_line <= 1'b1;  // Stop bit
              state   <= STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_line <= tx_byte[bit_idx + 3'd1];
            end
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        STOP: begin
          if (clk_count == BIT_LAST) state <= IDLE;
          clk_count <= clk_count + 1'b1;  // Wraps to 0 at end of frame
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && tx_valid) tx_byte <= tx_data;
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (state == IDLE) |-> tx_line)
    else $error("tx_line low while idle");

endmodule

//--- rtl/telemetry_parser.sv
// Telemetry packet parser with checksum check and held sensor fields
`timescale 1ns/1ps

module telemetry_parser import farm_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  byte_t  rx_data,
  input  logic   rx_valid,
  output level_t sensor_temp,
  output level_t sensor_humidity,
  output level_t sensor_light,
  output level_t sensor_soil,
  output fault_t fault_flags,
  output logic   packet_ok,   // Good checksum, fields committed
  output logic   packet_bad   // Bad checksum, fields kept
);

  parse_state_t state;
  pay_idx_t     pay_idx;    // Current payload byte
  byte_t        sum;        // Running mod-256 sum
  logic         sum_ok;
  // Shadow copies until the checksum passes
  level_t       sh_temp;
  level_t       sh_humidity;
  level_t       sh_light;
  level_t       sh_soil;
  fault_t       sh_faults;

  assign sum_ok = (rx_data == sum);

  // ====================================================================
  // Framing FSM and committed fields
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= HUNT;
      pay_idx         <= '0;
      packet_ok       <= 1'b0;
      packet_bad      <= 1'b0;
      sensor_temp     <= '0;
      sensor_humidity <= '0;
      sensor_light    <= '0;
      sensor_soil     <= '0;
      fault_flags     <= '0;
    end else begin
      packet_ok  <= 1'b0;
      packet_bad <= 1'b0;
      if (rx_valid) begin
        case (state)
          HUNT: begin
            pay_idx <= '0;
            if (rx_data == HEADER_BYTE) state <= PAYLOAD;  // Other bytes dropped
          end
          PAYLOAD: begin
            if (pay_idx == PAY_LAST) state <= CHECK;
            else pay_idx <= pay_idx + 1'b1;
          end
          CHECK: begin
            state <= HUNT;
            if (sum_ok) begin  // Commit all five at once
              sensor_temp     <= sh_temp;
              sensor_humidity <= sh_humidity;
              sensor_light    <= sh_light;
              sensor_soil     <= sh_soil;
              fault_flags     <= sh_faults;
              packet_ok       <= 1'b1;
            end else begin
              packet_bad <= 1'b1;
            end
          end
          default: state <= HUNT;
        endcase
      end
    end
  end

  // Payload capture and checksum accumulation
  always_ff @(posedge clk) begin
    if (rx_valid && state == HUNT) sum <= '0;
    if (rx_valid && state == PAYLOAD) begin
      sum <= sum + rx_data;
      case (pay_idx)
        3'd0: sh_temp     <= rx_data[1:0];
        3'd1: sh_humidity <= rx_data[1:0];
        3'd2: sh_light    <= rx_data[1:0];
        3'd3: sh_soil     <= rx_data[1:0];
        3'd4: sh_faults   <= rx_data;
        default: ;  // Actuator status, checksum only
      endcase
    end
  end

  a_ok_xor_bad: assert property (@(posedge clk) disable iff (!rst_n)
    !(packet_ok && packet_bad))
    else $error("packet_ok and packet_bad together");

endmodule

//--- rtl/field_monitor.sv
// Field monitor deciding sensor optimality, alert level and status LEDs
`timescale 1ns/1ps

module field_monitor import farm_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  level_t sensor_temp,
  input  level_t sensor_humidity,
  input  level_t sensor_light,
  input  level_t sensor_soil,
  input  fault_t fault_flags,
  input  logic   packet_ok,
  input  logic   packet_bad,
  output alert_t alert_level,
  output led_t   status_leds,
  output logic   fault_detected
);

  logic optimal;    // All four classes on target
  logic any_fault;

  assign optimal = (sensor_temp == OPTIMAL_LEVEL) && (sensor_humidity == OPTIMAL_LEVEL) &&
                   (sensor_light == OPTIMAL_LEVEL) && (sensor_soil == OPTIMAL_LEVEL);
  assign any_fault = |fault_flags;

  // ====================================================================
  // Registered outputs
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alert_level    <= ALERT_NORMAL;
      status_leds    <= '0;
      fault_detected <= 1'b0;
    end else begin
      // Fault outranks suboptimal
      if (any_fault) alert_level <= ALERT_FAULT;
      else if (!optimal) alert_level <= ALERT_SUBOPTIMAL;
      else alert_level <= ALERT_NORMAL;

      status_leds[LED_OPTIMAL] <= optimal;
      status_leds[LED_FAULT]   <= any_fault;
      fault_detected           <= any_fault;

      // Sticky until the next good packet
      if (packet_bad) status_leds[LED_CRC] <= 1'b1;
      else if (packet_ok) status_leds[LED_CRC] <= 1'b0;
    end
  end

  // Fault LED, fault output and top alert level move together
  a_fault_led: assert property (@(posedge clk) disable iff (!rst_n)
    (fault_detected == status_leds[LED_FAULT]) &&
    (fault_detected == (alert_level == ALERT_FAULT)))
    else $error("fault_detected disagrees with fault LED or alert level");

endmodule

//--- rtl/sensor_link_top.sv
// Sensor link top level joining UART, packet parser, field monitor and ACK sender
`timescale 1ns/1ps

module sensor_link_top import farm_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rx_line,        // From co-processor
  output logic   tx_line,        // ACK back to co-processor
  output alert_t alert_level,
  output led_t   status_leds,
  output logic   fault_detected
);

  // Receiver to parser
  byte_t  rx_data;
  logic   rx_valid;
  // Parser to monitor
  level_t sensor_temp;
  level_t sensor_humidity;
  level_t sensor_light;
  level_t sensor_soil;
  fault_t fault_flags;
  logic   packet_ok;              // Also the ACK request
  logic   packet_bad;

  uart_rx uart_rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_line  (rx_line),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  telemetry_parser telemetry_parser_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .rx_data         (rx_data),
    .rx_valid        (rx_valid),
    .sensor_temp     (sensor_temp),
    .sensor_humidity (sensor_humidity),
    .sensor_light    (sensor_light),
    .sensor_soil     (sensor_soil),
    .fault_flags     (fault_flags),
    .packet_ok       (packet_ok),
    .packet_bad      (packet_bad)
  );

  field_monitor field_monitor_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .sensor_temp     (sensor_temp),
    .sensor_humidity (sensor_humidity),
    .sensor_light    (sensor_light),
    .sensor_soil     (sensor_soil),
    .fault_flags     (fault_flags),
    .packet_ok       (packet_ok),
    .packet_bad      (packet_bad),
    .alert_level     (alert_level),
    .status_leds     (status_leds),
    .fault_detected  (fault_detected)
  );

  // One ACK per accepted packet
  uart_tx uart_tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_data  (ACK_BYTE),
    .tx_valid (packet_ok),
    .tx_line  (tx_line)
  );

endmodule

//--- verif/tb_sensor_link.sv
// Testbench for the sensor link, sends UART telemetry packets and checks alerts, LEDs and ACKs
`timescale 1ns/1ps

module tb_sensor_link import farm_pkg::*; ();

  // 12 packets of 100 bit periods, plus one packet's worth for noise bytes
  localparam int TEST_PACKETS   = 13;
  localparam int TIMEOUT_CYCLES = TEST_PACKETS * 100 * CLKS_PER_BIT;

  logic        clk;
  logic        rst_n;
  logic        rx_line;
  logic        tx_line;
  alert_t      alert_level;
  led_t        status_leds;
  logic        fault_detected;

  // Reference model, moves only on good packets
  logic        mdl_optimal;
  fault_t      mdl_faults;
  logic        mdl_crc;      // Sticky checksum error
  int          exp_acks;
  int          ack_count;    // Frames seen by the decoder
  byte_t       last_ack;
  int          errors = 0;
  int          cycles;
  logic [31:0] lfsr;

  sensor_link_top sensor_link_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_line        (rx_line),
    .tx_line        (tx_line),
    .alert_level    (alert_level),
    .status_leds    (status_leds),
    .fault_detected (fault_detected)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ====================================================================
  // Random source and checks
  // ====================================================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois taps 32,22,2,1
  endfunction

  // One LFSR step per bit taken
  function automatic byte_t rand_bits(input int n);
    byte_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("MISMATCH time=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_outputs();
    alert_t exp_alert;
    led_t   exp_leds;
    if (|mdl_faults) exp_alert = ALERT_FAULT;       // Fault wins
    else if (!mdl_optimal) exp_alert = ALERT_SUBOPTIMAL;
    else exp_alert = ALERT_NORMAL;
    exp_leds = {mdl_crc, |mdl_faults, mdl_optimal};
    check_value("alert_level", int'(alert_level), int'(exp_alert));
    check_value("status_leds", int'(status_leds), int'(exp_leds));
    check_value("fault_detected", int'(fault_detected), int'(|mdl_faults));
    check_value("ack_count", ack_count, exp_acks);
    if (exp_acks > 0) check_value("ack_byte", int'(last_ack), int'(ACK_BYTE));
  endtask

  // ====================================================================
  // UART stimulus
  // ====================================================================
  task automatic drive_bit(input logic b);
    rx_line <= b;
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic send_byte(input byte_t b);
    drive_bit(1'b0);                               // Start
    for (int i = 0; i < 8; i++) drive_bit(b[i]);   // LSB first
    drive_bit(1'b1);                               // Stop
  endtask

  task automatic send_packet(input byte_t temp, input byte_t hum, input byte_t light,
                             input byte_t soil, input byte_t faults, input byte_t act,
                             input logic corrupt);
    byte_t sum;
    sum = temp + hum + light + soil + faults + act;  // Mod 256
    if (corrupt) sum = sum ^ 8'h5a;
    send_byte(HEADER_BYTE);
    send_byte(temp);
    send_byte(hum);
    send_byte(light);
    send_byte(soil);
    send_byte(faults);
    send_byte(act);
    send_byte(sum);
    if (!corrupt) begin
      // Only bits 1:0 carry the class
      mdl_optimal = (temp[1:0] == OPTIMAL_LEVEL) && (hum[1:0] == OPTIMAL_LEVEL) &&
                    (light[1:0] == OPTIMAL_LEVEL) && (soil[1:0] == OPTIMAL_LEVEL);
      mdl_faults  = faults;
      mdl_crc     = 1'b0;
      exp_acks++;
    end else begin
      mdl_crc = 1'b1;
    end
    repeat (20 * CLKS_PER_BIT) @(posedge clk);  // ACK frame done by now
    check_outputs();
  endtask

  // ACK decoder, samples tx_line at mid-bit
  initial begin : ack_decoder
    byte_t b;
    ack_count = 0;
    last_ack  = '0;
    forever begin
      @(posedge clk);
      if (rst_n === 1'b1 && tx_line === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(posedge clk);  // Middle of start bit
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          b[i] = tx_line;
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        assert (tx_line === 1'b1) else begin
          $display("ACK frame ending at time %0t has a low stop bit", $time);
          errors++;
        end
        ack_count++;
        last_ack = b;
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin : stimulus
    byte_t noise;
    byte_t faults;
    rst_n       <= 1'b0;
    rx_line     <= 1'b1;  // Line idles high
    lfsr        = 32'he0912a7b;
    mdl_optimal = 1'b0;   // Classes reset to 0
    mdl_faults  = '0;
    mdl_crc     = 1'b0;
    exp_acks    = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    check_value("tx_line", int'(tx_line), 1);  // After reset
    check_outputs();

    send_packet(8'd2, 8'd2, 8'd2, 8'd2, 8'h00, 8'h3c, 1'b0);  // Optimal
    send_packet(8'd2, 8'd1, 8'd3, 8'd0, 8'h21, 8'h0f, 1'b0);  // Fault, mixed classes
    send_packet(8'd2, 8'd2, 8'd2, 8'd2, 8'h00, 8'h00, 1'b1);  // Bad checksum

    // Noise before a header, never AA
    repeat (3) begin
      noise = rand_bits(8);
      if (noise == HEADER_BYTE) noise = ~noise;
      send_byte(noise);
    end
    send_packet(8'hfe, 8'h06, 8'h8a, 8'h42, 8'h00, 8'h11, 1'b0);  // Clears CRC LED

    // Random payloads, faults in about a quarter of them
    repeat (8) begin
      faults = (rand_bits(2) == 8'd0) ? rand_bits(8) : 8'h00;
      send_packet(rand_bits(8), rand_bits(8), rand_bits(8), rand_bits(8),
                  faults, rand_bits(8), 1'b0);
    end

    $display("Checks done, %0d errors, %0d ACK frames", errors, ack_count);
    if (errors == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

endmodule

//--- src.f
rtl/farm_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/telemetry_parser.sv
rtl/field_monitor.sv
rtl/sensor_link_top.sv
verif/tb_sensor_link.sv

//--- Makefile
# Verilator build and run for the sensor link testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_sensor_link -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_sensor_link)"; echo "$$out"; \
		echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
